// File: event_counter.sv
// ****************************************
// Saturating event counter with clear
// ****************************************
`timescale 1ns/1ps

module event_counter (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear,
  input  logic              inc,
  input  harness_pkg::tmr_t limit,
  output harness_pkg::tmr_t count,
  output logic              at_limit
);

  assign at_limit = (count == limit); // Level flag, stays high while saturated

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      count <= '0;
    else if (clear)
      count <= '0;                    // Clear beats a same-cycle increment
    else if (inc && !at_limit)
      count <= count + 1'b1;          // Stops at limit instead of wrapping
  end

  // Holds as long as the limit does not drop below a count already reached
  a_count_le_limit: assert property (@(posedge clk) disable iff (!rst_n)
    count <= limit);

endmodule

// File: harness_cfg.svh
// ****************************************
// Build-time sizes for the message harness
// Message width, table depth, watchdog limit
// ****************************************
`ifndef HARNESS_CFG_SVH
`define HARNESS_CFG_SVH

// Width of one message in bits
`define VC_MSG_NBITS 13

// Entries in the source and the sink table
`define VC_NUM_MSGS 8

// Cycles the run phase may last before the watchdog fires
`define VC_TIMEOUT_CYCLES 2000

`endif

// File: harness_ctrl_fsm.sv
// ****************************************
// Run controller for the message harness
// ****************************************
`timescale 1ns/1ps

module harness_ctrl_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start_valid,
  input  harness_pkg::start_req_t start_req,
  input  harness_pkg::count_t    recv_count,
  input  logic                   miss,
  input  logic                   timeout,
  output logic                   start_ready,
  output logic                   load_ready,
  output logic                   run_en,
  output logic                   clear,
  output harness_pkg::count_t    run_count,
  output harness_pkg::status_t   status
);
  import harness_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        start_xfer;
  logic        done_q;
  logic        pass_q;
  logic        fail_mm_q;
  logic        fail_to_q;

  assign start_ready = (state == IDLE) || (state == DONE); // Commands only between runs
  assign load_ready  = start_ready;                        // Tables stay frozen during a run
  assign start_xfer  = start_valid && start_ready;
  assign clear       = start_xfer;                         // Wipes counters and consumed flags
  assign run_en      = (state == RUN);

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE, DONE:
      begin
        if (start_xfer)
          state_nxt = RUN;
      end
      RUN:
      begin
        if (miss || timeout)
          state_nxt = DONE;                  // A failure ends the run at once
        else if (recv_count == run_count)
          state_nxt = CHECK;                 // All expected messages matched
      end
      CHECK:
        state_nxt = DONE;
      default:
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      run_count <= '0;
      done_q    <= 1'b0;
      pass_q    <= 1'b0;
      fail_mm_q <= 1'b0;
      fail_to_q <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (start_xfer)
      begin
        run_count <= start_req.count; // Latched for the whole run
        done_q    <= 1'b0;            // A new start drops the old verdict
        pass_q    <= 1'b0;
        fail_mm_q <= 1'b0;
        fail_to_q <= 1'b0;
      end
      else if (state == RUN)
      begin
        if (miss)
        begin
          done_q    <= 1'b1;
          fail_mm_q <= 1'b1;          // Mismatch wins over a same-cycle timeout
        end
        else if (timeout)
        begin
          done_q    <= 1'b1;
          fail_to_q <= 1'b1;
        end
      end
      else if (state == CHECK)
      begin
        done_q <= 1'b1;
        pass_q <= 1'b1;
      end
    end
  end

  // The count field follows the received counter, which stops moving once the run ends
  assign status = '{
    done:          done_q,
    pass:          pass_q,
    fail_mismatch: fail_mm_q,
    fail_timeout:  fail_to_q,
    recv_count:    recv_count
  };

  // The checker may only report a miss while the controller is running
  a_miss_in_run: assert property (@(posedge clk) disable iff (!rst_n)
    miss |-> (state == RUN));

  // A finished run carries exactly one verdict
  a_one_verdict: assert property (@(posedge clk) disable iff (!rst_n)
    status.done |-> $onehot({status.pass, status.fail_mismatch, status.fail_timeout}));

endmodule

// File: harness_pkg.sv
// ****************************************
// Shared types for the message harness
// Vector typedefs, channel structs, FSM states
// ****************************************
`include "harness_cfg.svh"

package harness_pkg;

  typedef logic [`VC_MSG_NBITS-1:0]        msg_t;   // One message on the link
  typedef logic [$clog2(`VC_NUM_MSGS)-1:0] idx_t;   // Index into either table
  typedef logic [$clog2(`VC_NUM_MSGS):0]   count_t; // Holds zero up to VC_NUM_MSGS
  typedef logic [15:0]                     tmr_t;   // Counter and watchdog width

  // One table write on the load channel
  typedef struct packed {
    logic target; // Zero writes the source, one writes the sink
    idx_t idx;    // Entry to write
    msg_t msg;    // Value stored at that entry
  } load_req_t;

  // Start command for one run
  typedef struct packed {
    count_t count; // Messages the source sends in this run
  } start_req_t;

  // Run verdict, held until the next start
  typedef struct packed {
    logic   done;          // Run has ended
    logic   pass;          // Every message matched
    logic   fail_mismatch; // A message had no eligible entry
    logic   fail_timeout;  // Watchdog expired first
    count_t recv_count;    // Messages matched so far
  } status_t;

  // Controller sequence
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    CHECK = 2'd2,
    DONE  = 2'd3
  } ctrl_state_t;

endpackage

// File: msg_harness_tb.sv
// ****************************************
// Directed testbench for the message harness
// ****************************************
`timescale 1ns/1ps
`include "harness_cfg.svh"

module msg_harness_tb;
  import harness_pkg::*;

  localparam int HS_LIMIT  = 20;                       // Cycles allowed for a handshake
  localparam int RUN_LIMIT = `VC_TIMEOUT_CYCLES + 100; // Watchdog limit plus some slack

  logic       clk;
  logic       rst_n;
  logic       load_valid;
  logic       load_ready;
  load_req_t  load_req;
  logic       start_valid;
  logic       start_ready;
  start_req_t start_req;
  logic       stall;
  status_t    status;

  msg_t src_tab [0:`VC_NUM_MSGS-1]; // What the source table should hold
  msg_t snk_tab [0:`VC_NUM_MSGS-1]; // What the sink table should hold
  int   err_count;
  int   timeout_count;
  int   stall_mode;                 // 0 keeps stall low, 1 random level, 2 held high
  int   run_cycles;                 // Cycles from the start transfer to done

  msg_harness_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_valid  (load_valid),
    .load_ready  (load_ready),
    .load_req    (load_req),
    .start_valid (start_valid),
    .start_ready (start_ready),
    .start_req   (start_req),
    .stall       (stall),
    .status      (status)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      err_count++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // One write on the shared load port, held until the controller takes it
  task automatic load_msg(input logic tgt, input idx_t at, input msg_t val);
    int waited;
    waited = 0;
    @(posedge clk);
    load_valid <= 1'b1;
    load_req   <= '{target: tgt, idx: at, msg: val};
    @(negedge clk);
    while (!load_ready && waited < HS_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!load_ready)
    begin
      timeout_count++;
      $display("Load channel never became ready for index %0d", at);
    end
    @(posedge clk);
    load_valid <= 1'b0; // The transfer completes on this edge
  endtask

  task automatic load_tables(input int n);
    for (int i = 0; i < n; i++)
    begin
      load_msg(1'b0, idx_t'(i), src_tab[i]);
      load_msg(1'b1, idx_t'(i), snk_tab[i]);
    end
  endtask

  task automatic drive_stall();
    case (stall_mode)
      1:       stall <= ($urandom_range(1, 0) != 0); // Fresh level every cycle
      2:       stall <= 1'b1;
      default: stall <= 1'b0;
    endcase
  endtask

  // Issues a start for n messages and waits for status.done
  task automatic run_and_wait(input int n);
    int waited;
    waited = 0;
    @(posedge clk);
    start_valid <= 1'b1;
    start_req   <= '{count: count_t'(n)};
    @(negedge clk);
    while (!start_ready && waited < HS_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!start_ready)
    begin
      timeout_count++;
      $display("Start channel never became ready");
    end
    @(posedge clk);
    start_valid <= 1'b0;
    drive_stall();
    run_cycles = 0;
    @(negedge clk);
    while (!status.done && run_cycles < RUN_LIMIT)
    begin
      @(posedge clk);
      drive_stall();
      @(negedge clk);
      run_cycles++;
    end
    if (!status.done)
    begin
      timeout_count++;
      $display("Run of %0d messages never reported done", n);
    end
  endtask

  task automatic check_status(input logic pass, input logic mm, input logic to, input int recv);
    check_eq("status.done", 32'(status.done), 32'd1);
    check_eq("status.pass", 32'(status.pass), 32'(pass));
    check_eq("status.fail_mismatch", 32'(status.fail_mismatch), 32'(mm));
    check_eq("status.fail_timeout", 32'(status.fail_timeout), 32'(to));
    check_eq("status.recv_count", 32'(status.recv_count), recv);
  endtask

  // First value above seed that no source entry below n holds
  function automatic msg_t absent_value(input msg_t seed, input int n);
    msg_t cand;
    logic found;
    cand  = seed;
    found = 1'b1;
    while (found)
    begin
      cand  = cand + 1'b1;
      found = 1'b0;
      for (int i = 0; i < n; i++)
        if (src_tab[i] == cand)
          found = 1'b1;
    end
    return cand;
  endfunction

  task automatic set_ref_tables();
    src_tab[0] = 13'h0a5c;
    src_tab[1] = 13'h1f01;
    src_tab[2] = 13'h0033;
    src_tab[3] = 13'h17e2;
    src_tab[4] = 13'h0c4d;
    src_tab[5] = 13'h1b90;
    for (int i = 0; i < 6; i++)
      snk_tab[i] = src_tab[i]; // Same order on both sides
  endtask

  task automatic test_ordered();
    set_ref_tables();
    load_tables(6);
    run_and_wait(6);
    check_status(1'b1, 1'b0, 1'b0, 6);
  endtask

  task automatic test_reversed();
    for (int i = 0; i < 6; i++)
      snk_tab[i] = src_tab[5-i];
    load_tables(6);
    run_and_wait(6);
    check_status(1'b1, 1'b0, 1'b0, 6);
  endtask

  task automatic test_random_stall();
    int   j;
    msg_t tmp;
    for (int i = 0; i < `VC_NUM_MSGS; i++)
    begin
      src_tab[i] = msg_t'($urandom);
      snk_tab[i] = src_tab[i];
    end
    for (int i = `VC_NUM_MSGS - 1; i > 0; i--)
    begin
      j          = $urandom_range(i, 0); // In-place shuffle of the sink copy
      tmp        = snk_tab[i];
      snk_tab[i] = snk_tab[j];
      snk_tab[j] = tmp;
    end
    load_tables(`VC_NUM_MSGS);
    stall_mode = 1;
    run_and_wait(`VC_NUM_MSGS);
    stall_mode = 0;
    check_status(1'b1, 1'b0, 1'b0, `VC_NUM_MSGS);
  endtask

  task automatic test_mismatch();
    int k;
    k = 3;
    set_ref_tables();
    snk_tab[k] = absent_value(src_tab[k], 6); // Source entry k then has nowhere to go
    load_tables(6);
    run_and_wait(6);
    check_status(1'b0, 1'b1, 1'b0, k);
  endtask

  task automatic test_timeout();
    set_ref_tables();
    load_tables(6);
    stall_mode = 2;
    run_and_wait(6);
    stall_mode = 0;
    check_status(1'b0, 1'b0, 1'b1, 0);
    if (run_cycles < `VC_TIMEOUT_CYCLES)
    begin
      err_count++;
      $display("Watchdog ended the run after only %0d cycles", run_cycles);
    end
  endtask

  // Second start without reloading, flags and counts must begin from zero
  task automatic test_reuse();
    @(negedge clk);
    check_eq("load_ready", 32'(load_ready), 32'd1);
    run_and_wait(3);
    check_status(1'b1, 1'b0, 1'b0, 3);
  endtask

  initial
  begin
    void'($urandom(32'h20c9));
    rst_n         = 1'b0;
    load_valid    = 1'b0;
    load_req      = '0;
    start_valid   = 1'b0;
    start_req     = '0;
    stall         = 1'b0;
    err_count     = 0;
    timeout_count = 0;
    stall_mode    = 0;
    run_cycles    = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq("status", 32'(status), 32'd0);
    check_eq("start_ready", 32'(start_ready), 32'd1);
    test_ordered();
    test_reuse();     // Follows a full run, so every flag and count starts out set
    test_reversed();
    test_random_stall();
    test_mismatch();
    test_timeout();
    $display("Closing count: %0d value errors, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: msg_harness_top.sv
// ****************************************
// Message harness top level
// Controller, counters, source and checker
// ****************************************
`timescale 1ns/1ps
`include "harness_cfg.svh"

module msg_harness_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    load_valid,
  output logic                    load_ready,
  input  harness_pkg::load_req_t  load_req,
  input  logic                    start_valid,
  output logic                    start_ready,
  input  harness_pkg::start_req_t start_req,
  input  logic                    stall,
  output harness_pkg::status_t    status
);
  import harness_pkg::*;

  logic   load_we;      // One load transfer, each table checks the target bit
  logic   run_en;
  logic   clear;
  count_t run_count;
  logic   src_valid;
  logic   src_ready;
  msg_t   src_msg;
  logic   hit;
  logic   miss;
  logic   timeout;
  tmr_t   sent_cnt_raw; // Only the low count_t bits are meaningful
  tmr_t   recv_cnt_raw;

  assign load_we = load_valid && load_ready;

  harness_ctrl_fsm u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_valid (start_valid),
    .start_req   (start_req),
    .recv_count  (count_t'(recv_cnt_raw)),
    .miss        (miss),
    .timeout     (timeout),
    .start_ready (start_ready),
    .load_ready  (load_ready),
    .run_en      (run_en),
    .clear       (clear),
    .run_count   (run_count),
    .status      (status)
  );

  // Counts link transfers and doubles as the source read index
  event_counter u_sent_cnt (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear    (clear),
    .inc      (src_valid && src_ready),
    .limit    (tmr_t'(`VC_NUM_MSGS)),
    .count    (sent_cnt_raw),
    .at_limit ()
  );

  // Counts matched messages for the completion compare
  event_counter u_recv_cnt (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear    (clear),
    .inc      (hit),
    .limit    (tmr_t'(`VC_NUM_MSGS)),
    .count    (recv_cnt_raw),
    .at_limit ()
  );

  // Runs on every RUN cycle, stalled or not
  event_counter u_watchdog (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear    (clear),
    .inc      (run_en),
    .limit    (tmr_t'(`VC_TIMEOUT_CYCLES)),
    .count    (),
    .at_limit (timeout)
  );

  msg_source u_source (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_we    (load_we),
    .load_req   (load_req),
    .run_en     (run_en),
    .sent_count (count_t'(sent_cnt_raw)),
    .run_count  (run_count),
    .src_ready  (src_ready),
    .src_valid  (src_valid),
    .src_msg    (src_msg)
  );

  unordered_match u_sink (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_we   (load_we),
    .load_req  (load_req),
    .clear     (clear),
    .run_en    (run_en),
    .stall     (stall),
    .src_valid (src_valid),
    .src_msg   (src_msg),
    .run_count (run_count),
    .src_ready (src_ready),
    .hit       (hit),
    .miss      (miss)
  );

endmodule

// File: msg_source.sv
// ****************************************
// Message source table with valid/ready output
// ****************************************
`timescale 1ns/1ps
`include "harness_cfg.svh"

module msg_source (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load_we,
  input  harness_pkg::load_req_t load_req,
  input  logic                   run_en,
  input  harness_pkg::count_t    sent_count,
  input  harness_pkg::count_t    run_count,
  input  logic                   src_ready,
  output logic                   src_valid,
  output harness_pkg::msg_t      src_msg
);
  import harness_pkg::*;

  msg_t mem [0:`VC_NUM_MSGS-1]; // Messages in send order

  // Table write from the shared load port, target zero only
  always_ff @(posedge clk)
  begin
    if (load_we && !load_req.target)
      mem[load_req.idx] <= load_req.msg;
  end

  // The sent counter is the registered read index, so the handshake has no bubble
  assign src_valid = run_en && (sent_count < run_count);
  assign src_msg   = mem[idx_t'(sent_count)]; // Don't care once all entries are sent

  // Under back-pressure the offer must stay put until the sink takes it
  // An aborted run is the only way an offer is withdrawn
  a_msg_stable: assert property (@(posedge clk) disable iff (!rst_n)
    src_valid && !src_ready |=> (src_valid || !run_en) && $stable(src_msg));

endmodule

// File: run.sh
#!/bin/sh
# Build the message harness testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module msg_harness_tb -f tb.f
if ! ./obj_dir/Vmsg_harness_tb > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi
cat sim.log
if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0

// File: tb.f
+incdir+.
harness_pkg.sv
event_counter.sv
harness_ctrl_fsm.sv
msg_source.sv
unordered_match.sv
msg_harness_top.sv
msg_harness_tb.sv

// File: unordered_match.sv
// ****************************************
// Unordered checker with consumed flags
// ****************************************
`timescale 1ns/1ps
`include "harness_cfg.svh"

module unordered_match (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load_we,
  input  harness_pkg::load_req_t load_req,
  input  logic                   clear,
  input  logic                   run_en,
  input  logic                   stall,
  input  logic                   src_valid,
  input  harness_pkg::msg_t      src_msg,
  input  harness_pkg::count_t    run_count,
  output logic                   src_ready,
  output logic                   hit,
  output logic                   miss
);
  import harness_pkg::*;

  msg_t                   exp_mem [0:`VC_NUM_MSGS-1]; // Expected messages, any order
  logic [`VC_NUM_MSGS-1:0] consumed;                  // Set once an entry has matched
  logic [`VC_NUM_MSGS-1:0] eligible;                  // Live entries equal to src_msg
  logic                   xfer;
  logic                   any_match;
  idx_t                   match_idx;

  // Expected table write, target one only
  always_ff @(posedge clk)
  begin
    if (load_we && load_req.target)
      exp_mem[load_req.idx] <= load_req.msg;
  end

  assign src_ready = run_en && !stall; // Stall throttles the link from outside
  assign xfer      = src_valid && src_ready;

  // Only entries inside the run and not yet consumed can match
  always_comb
  begin
    for (int i = 0; i < `VC_NUM_MSGS; i++)
      eligible[i] = (count_t'(i) < run_count) && !consumed[i] && (exp_mem[i] == src_msg);
  end

  // Scan downwards so the lowest matching index is the one kept
  always_comb
  begin
    any_match = 1'b0;
    match_idx = '0;
    for (int i = `VC_NUM_MSGS - 1; i >= 0; i--)
    begin
      if (eligible[i])
      begin
        any_match = 1'b1;
        match_idx = idx_t'(i);
      end
    end
  end

  assign hit  = xfer && any_match;
  assign miss = xfer && !any_match;   // Also covers a repeat of a consumed message

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      consumed <= '0;
    else if (clear)
      consumed <= '0;                 // Every run starts with the full table
    else if (hit)
      consumed[match_idx] <= 1'b1;    // Takes effect for the next transfer
  end

  // A transfer is counted as exactly one of the two outcomes
  a_hit_miss_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(hit && miss));

endmodule
